// File: Makefile
VERILATOR ?= verilator
TOP       ?= udp_echo_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/axis_pkg.sv
// Payload beat widths and types for the 64-bit datapath.
// One keep bit per data byte; user is a single error flag bit.
package axis_pkg;

    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    typedef logic [DATA_W-1:0] beat_data_t;
    typedef logic [KEEP_W-1:0] beat_keep_t;

endpackage

// File: common/net_pkg.sv
// UDP and IPv4 header field types for the echo core.
// Only the fields the echo path touches are described here.
// The constant reply fields (TTL, DSCP, local IP) come from the transmit stack.
package net_pkg;

    // IPv4 address, network order as one word
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload in bytes
    typedef logic [15:0] udp_len_t;

    // Port answered by the echo core unless the top level overrides it
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

endpackage

// File: echo/echo_fifo.sv
`timescale 1ns/1ps
// Synchronous first-word-fall-through FIFO for payload beats.
// The head entry is read straight from memory, so a beat shows one cycle after its write.
// FIFO_DEPTH must be a power of two and at least 2.
module echo_fifo import axis_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  beat_data_t wr_data,
    input  beat_keep_t wr_keep,
    input  logic       wr_last,
    input  logic       wr_user,
    output beat_data_t out_tdata,
    output beat_keep_t out_tkeep,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,
    output logic       out_tuser
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(FIFO_DEPTH);

    beat_data_t data_mem [FIFO_DEPTH];
    beat_keep_t keep_mem [FIFO_DEPTH];
    logic       last_mem [FIFO_DEPTH];
    logic       user_mem [FIFO_DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              do_wr;
    logic              do_rd;

    assign wr_ready   = (count != FULL_COUNT);
    assign out_tvalid = (count != '0);
    assign do_wr      = wr_valid && wr_ready;
    assign do_rd      = out_tvalid && out_tready;

    // Head of queue
    assign out_tdata = data_mem[rd_ptr];
    assign out_tkeep = keep_mem[rd_ptr];
    assign out_tlast = last_mem[rd_ptr];
    assign out_tuser = user_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            data_mem[wr_ptr] <= wr_data;
            keep_mem[wr_ptr] <= wr_keep;
            last_mem[wr_ptr] <= wr_last;
            user_mem[wr_ptr] <= wr_user;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: echo/echo_hdr_swap.sv
`timescale 1ns/1ps
// Header path of the echo core, fully combinational from input to reply.
// Holds one forward/drop decision until the payload gate reports the last beat,
// so only one datagram at a time sits between header and payload.
module echo_hdr_swap import net_pkg::*; #(
    parameter udp_port_t ECHO_PORT = DEFAULT_ECHO_PORT
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_hdr_valid,
    output logic      in_hdr_ready,
    input  ip_addr_t  in_src_ip,
    input  udp_port_t in_src_port,
    input  udp_port_t in_dst_port,
    input  udp_len_t  in_length,
    output logic      out_hdr_valid,
    input  logic      out_hdr_ready,
    output ip_addr_t  out_dst_ip,
    output udp_port_t out_src_port,
    output udp_port_t out_dst_port,
    output udp_len_t  out_length,
    output logic      dec_valid,
    output logic      dec_fwd,
    input  logic      dec_done
);

    logic port_match;
    logic hdr_xfer;

    assign port_match = (in_dst_port == ECHO_PORT);

    // Non-matching headers are swallowed without waiting on the reply side
    assign in_hdr_ready  = !dec_valid && (!port_match || out_hdr_ready);
    assign out_hdr_valid = in_hdr_valid && port_match && !dec_valid;
    assign hdr_xfer      = in_hdr_valid && in_hdr_ready;

    // Reply fields
    assign out_dst_ip   = in_src_ip;
    assign out_src_port = in_dst_port;
    assign out_dst_port = in_src_port;
    assign out_length   = in_length;

    // One-entry decision register
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec_fwd   <= 1'b0;
        end else if (hdr_xfer) begin
            dec_valid <= 1'b1;
            dec_fwd   <= port_match;
        end else if (dec_done) begin
            dec_valid <= 1'b0;
        end
    end

endmodule

// File: echo/echo_payload_gate.sv
`timescale 1ns/1ps
// Payload path: passes beats to the FIFO or drops them per the held decision.
// Beats are stalled until a header decision exists for their datagram.
// led keeps the low byte of the first beat of the latest forwarded datagram.
module echo_payload_gate import axis_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  beat_data_t in_tdata,
    input  beat_keep_t in_tkeep,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  logic       in_tlast,
    input  logic       in_tuser,
    input  logic       dec_valid,
    input  logic       dec_fwd,
    output logic       dec_done,
    output logic       wr_valid,
    input  logic       wr_ready,
    output beat_data_t wr_data,
    output beat_keep_t wr_keep,
    output logic       wr_last,
    output logic       wr_user,
    output logic [7:0] led
);

    logic beat_xfer;
    logic first_beat;

    // Dropped beats are accepted regardless of FIFO space
    assign in_tready = dec_valid && (!dec_fwd || wr_ready);
    assign beat_xfer = in_tvalid && in_tready;
    assign dec_done  = beat_xfer && in_tlast;

    assign wr_valid = in_tvalid && dec_valid && dec_fwd;
    assign wr_data  = in_tdata;
    assign wr_keep  = in_tkeep;
    assign wr_last  = in_tlast;
    assign wr_user  = in_tuser;

    // Frame start tracking, covers dropped frames too
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
        end else if (beat_xfer) begin
            first_beat <= in_tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= 8'd0;
        end else if (beat_xfer && dec_fwd && first_beat) begin
            led <= in_tdata[7:0];
        end
    end

endmodule

// File: files.f
common/net_pkg.sv
common/axis_pkg.sv
echo/echo_hdr_swap.sv
echo/echo_payload_gate.sv
echo/echo_fifo.sv
hdl/udp_echo_core.sv
tb/udp_echo_tb.sv

// File: hdl/udp_echo_core.sv
`timescale 1ns/1ps
// UDP echo core: replies to datagrams sent to ECHO_PORT with ports and IP swapped.
// Constant reply fields are not driven here and must be added downstream.
// Payload of non-matching datagrams is consumed and discarded.
// FIFO_DEPTH must be a power of two, at least 2.
module udp_echo_core import net_pkg::*, axis_pkg::*; #(
    parameter udp_port_t ECHO_PORT  = DEFAULT_ECHO_PORT,
    parameter int        FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst,

    input  logic       in_hdr_valid,
    output logic       in_hdr_ready,
    input  ip_addr_t   in_src_ip,
    input  udp_port_t  in_src_port,
    input  udp_port_t  in_dst_port,
    input  udp_len_t   in_length,

    output logic       out_hdr_valid,
    input  logic       out_hdr_ready,
    output ip_addr_t   out_dst_ip,
    output udp_port_t  out_src_port,
    output udp_port_t  out_dst_port,
    output udp_len_t   out_length,

    input  beat_data_t in_tdata,
    input  beat_keep_t in_tkeep,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  logic       in_tlast,
    input  logic       in_tuser,

    output beat_data_t out_tdata,
    output beat_keep_t out_tkeep,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,
    output logic       out_tuser,

    output logic [7:0] led
);

    // Per-datagram decision from header path to payload path
    logic dec_valid;
    logic dec_fwd;
    logic dec_done;

    // Gate into FIFO
    logic       wr_valid;
    logic       wr_ready;
    beat_data_t wr_data;
    beat_keep_t wr_keep;
    logic       wr_last;
    logic       wr_user;

    echo_hdr_swap #(
        .ECHO_PORT(ECHO_PORT)
    ) u_hdr_swap (
        .clk(clk),
        .rst(rst),
        .in_hdr_valid(in_hdr_valid),
        .in_hdr_ready(in_hdr_ready),
        .in_src_ip(in_src_ip),
        .in_src_port(in_src_port),
        .in_dst_port(in_dst_port),
        .in_length(in_length),
        .out_hdr_valid(out_hdr_valid),
        .out_hdr_ready(out_hdr_ready),
        .out_dst_ip(out_dst_ip),
        .out_src_port(out_src_port),
        .out_dst_port(out_dst_port),
        .out_length(out_length),
        .dec_valid(dec_valid),
        .dec_fwd(dec_fwd),
        .dec_done(dec_done)
    );

    echo_payload_gate u_payload_gate (
        .clk(clk),
        .rst(rst),
        .in_tdata(in_tdata),
        .in_tkeep(in_tkeep),
        .in_tvalid(in_tvalid),
        .in_tready(in_tready),
        .in_tlast(in_tlast),
        .in_tuser(in_tuser),
        .dec_valid(dec_valid),
        .dec_fwd(dec_fwd),
        .dec_done(dec_done),
        .wr_valid(wr_valid),
        .wr_ready(wr_ready),
        .wr_data(wr_data),
        .wr_keep(wr_keep),
        .wr_last(wr_last),
        .wr_user(wr_user),
        .led(led)
    );

    echo_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk(clk),
        .rst(rst),
        .wr_valid(wr_valid),
        .wr_ready(wr_ready),
        .wr_data(wr_data),
        .wr_keep(wr_keep),
        .wr_last(wr_last),
        .wr_user(wr_user),
        .out_tdata(out_tdata),
        .out_tkeep(out_tkeep),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .out_tlast(out_tlast),
        .out_tuser(out_tuser)
    );

endmodule

// File: tb/udp_echo_tb.sv
`timescale 1ns/1ps
// Random echo traffic with stalls on both reply streams.
// Expected replies come from expected_reply() and are checked in order.
// led is checked only once all outstanding replies have drained.
module udp_echo_tb import net_pkg::*, axis_pkg::*;;

    localparam udp_port_t   ECHO_PORT   = DEFAULT_ECHO_PORT;
    localparam int          FIFO_DEPTH  = 16;
    localparam int          CLK_PERIOD  = 8;
    localparam int          FRAMES      = 40;
    localparam logic [31:0] SEED        = 32'd85786;
    localparam int          WATCHDOG_NS = FRAMES * 10 * CLK_PERIOD * 4;

    logic       clk;
    logic       rst;
    logic       in_hdr_valid;
    logic       in_hdr_ready;
    ip_addr_t   in_src_ip;
    udp_port_t  in_src_port;
    udp_port_t  in_dst_port;
    udp_len_t   in_length;
    logic       out_hdr_valid;
    logic       out_hdr_ready;
    ip_addr_t   out_dst_ip;
    udp_port_t  out_src_port;
    udp_port_t  out_dst_port;
    udp_len_t   out_length;
    beat_data_t in_tdata;
    beat_keep_t in_tkeep;
    logic       in_tvalid;
    logic       in_tready;
    logic       in_tlast;
    logic       in_tuser;
    beat_data_t out_tdata;
    beat_keep_t out_tkeep;
    logic       out_tvalid;
    logic       out_tready;
    logic       out_tlast;
    logic       out_tuser;
    logic [7:0] led;

    // {dst_ip, src_port, dst_port, length} and {user, last, keep, data}
    logic [79:0] exp_hdr_q [$];
    logic [73:0] exp_beat_q [$];

    logic [31:0] stim_state;
    logic [31:0] ready_state;
    logic [7:0]  last_fwd_byte;
    int          value_errors;
    int          other_errors;

    udp_echo_core #(
        .ECHO_PORT(ECHO_PORT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Bit 80 set when the datagram is echoed
    function automatic logic [80:0] expected_reply(input ip_addr_t src_ip,
        input udp_port_t src_port, input udp_port_t dst_port, input udp_len_t length);
        if (dst_port != ECHO_PORT) begin
            return '0;
        end
        return {1'b1, src_ip, dst_port, src_port, length};
    endfunction

    task automatic next_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic send_frame();
        logic [80:0] reply;
        logic [73:0] beats [6];
        logic        echo;
        beat_keep_t  keep;
        int          nbeats;
        int          nbytes;
        stim_state = lcg_next(stim_state);
        in_src_ip = stim_state;
        stim_state = lcg_next(stim_state);
        in_src_port = stim_state[31:16];
        echo = stim_state[15:14] != 2'b00;
        stim_state = lcg_next(stim_state);
        in_dst_port = echo ? ECHO_PORT : stim_state[31:16];
        if (!echo && in_dst_port == ECHO_PORT) begin
            in_dst_port = in_dst_port ^ 16'd1;
        end
        nbeats = 1 + int'((stim_state >> 8) % 32'd6);
        stim_state = lcg_next(stim_state);
        nbytes = 1 + int'((stim_state >> 20) % 32'd8);
        in_length = 16'(8 + (nbeats - 1) * 8 + nbytes);
        for (int i = 0; i < nbeats; i++) begin
            keep = (i == nbeats - 1) ? 8'hff >> (8 - nbytes) : 8'hff;
            stim_state = lcg_next(stim_state);
            beats[i][63:32] = stim_state;
            stim_state = lcg_next(stim_state);
            beats[i][31:0] = stim_state;
            beats[i][73:64] = {stim_state[21] & stim_state[20], i == nbeats - 1, keep};
        end
        reply = expected_reply(in_src_ip, in_src_port, in_dst_port, in_length);
        if (reply[80]) begin
            exp_hdr_q.push_back(reply[79:0]);
            for (int i = 0; i < nbeats; i++) begin
                exp_beat_q.push_back(beats[i]);
            end
            last_fwd_byte = beats[0][7:0];
        end
        in_hdr_valid = 1'b1;
        @(negedge clk);
        while (!in_hdr_ready) @(negedge clk);
        next_slot();
        in_hdr_valid = 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            {in_tuser, in_tlast, in_tkeep, in_tdata} = beats[i];
            in_tvalid = 1'b1;
            @(negedge clk);
            while (!in_tready) @(negedge clk);
            next_slot();
        end
        in_tvalid = 1'b0;
    endtask

    task automatic drain_and_check_led();
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) @(negedge clk);
        next_slot();
        assert (led == last_fwd_byte) else begin
            value_errors++;
            $display("ERROR %0t: led %h, expected %h", $time, led, last_fwd_byte);
        end
    endtask

    // Reply stream stalls
    initial begin
        ready_state = SEED ^ 32'h5a5a_5a5a;
        @(negedge rst);
        forever begin
            @(posedge clk);
            #1;
            ready_state = lcg_next(ready_state);
            out_hdr_ready = ready_state[31:30] != 2'b00;
            out_tready = ready_state[29:28] != 2'b00;
        end
    end

    // Transfers complete on the next rising edge, so the falling edge sees stable values
    always @(negedge clk) begin : monitor
        logic [79:0] got_hdr;
        logic [73:0] got_beat;
        if (!rst && out_hdr_valid && out_hdr_ready) begin
            got_hdr = {out_dst_ip, out_src_port, out_dst_port, out_length};
            // Reply header shares its cycle with the input header transfer
            assert (in_hdr_valid && in_hdr_ready) else begin
                other_errors++;
                $display("Reply header sent at %0t without an input header accepted %s",
                    $time, "in the same cycle");
            end
            assert (exp_hdr_q.size() != 0) else begin
                other_errors++;
                $display("Reply header sent at %0t with no echoed datagram outstanding", $time);
            end
            if (exp_hdr_q.size() != 0) begin
                assert (got_hdr == exp_hdr_q[0]) else begin
                    value_errors++;
                    $display("ERROR %0t: reply header %h, expected %h",
                        $time, got_hdr, exp_hdr_q[0]);
                end
                void'(exp_hdr_q.pop_front());
            end
        end
        if (!rst && out_tvalid && out_tready) begin
            got_beat = {out_tuser, out_tlast, out_tkeep, out_tdata};
            assert (exp_beat_q.size() != 0) else begin
                other_errors++;
                $display("Reply beat sent at %0t with no echoed payload outstanding", $time);
            end
            if (exp_beat_q.size() != 0) begin
                assert (got_beat == exp_beat_q[0]) else begin
                    value_errors++;
                    $display("ERROR %0t: reply beat %h, expected %h",
                        $time, got_beat, exp_beat_q[0]);
                end
                void'(exp_beat_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: replies still outstanding after %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
        $finish;
    end

    initial begin
        rst = 1'b1;
        in_hdr_valid = 1'b0;
        in_src_ip = '0;
        in_src_port = '0;
        in_dst_port = '0;
        in_length = '0;
        out_hdr_ready = 1'b0;
        in_tdata = '0;
        in_tkeep = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        out_tready = 1'b0;
        stim_state = SEED;
        last_fwd_byte = 8'd0;
        value_errors = 0;
        other_errors = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!out_hdr_valid && !out_tvalid && !in_tready && led == 8'd0) else begin
            value_errors++;
            $display("ERROR %0t: outputs not idle after reset", $time);
        end
        for (int f = 0; f < FRAMES; f++) begin
            send_frame();
            stim_state = lcg_next(stim_state);
            if (stim_state[31:30] == 2'b00 || f == FRAMES - 1) begin
                drain_and_check_led();
            end
        end
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        $finish;
    end

endmodule
